// ==== logic/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    // Datapath and register file sizing
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Fetch queue sizing, depth must stay a power of two
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = 2;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // ALU function select
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

    // Register-register format
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } rv_inst_r_t;

    // Register-immediate format
    typedef struct packed {
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } rv_inst_i_t;

    // Upper-immediate format
    typedef struct packed {
        logic [19:0]           imm20;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } rv_inst_u_t;

    // One fetched word, viewed through the format its opcode selects
    typedef union packed {
        rv_inst_r_t r;
        rv_inst_i_t i;
        rv_inst_u_t u;
    } rv_inst_u;

    // Queue payload
    typedef struct packed {
        logic [XLEN-1:0] pc;
        rv_inst_u        inst;
    } fetch_entry_t;

    // One retired instruction
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wdata;
        logic                  illegal;
    } retire_t;

endpackage

`default_nettype wire

// ==== logic/rv_fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_fetch_unit (
    input  logic                             clk,
    input  logic                             i_rst,
    input  logic                             i_almost_full,
    input  logic [rv_core_pkg::XLEN-1:0]     i_imem_rdata,
    output logic                             o_imem_req,
    output logic [rv_core_pkg::XLEN-1:0]     o_imem_addr,
    output logic                             o_push,
    output rv_core_pkg::fetch_entry_t        o_entry
);

    logic [rv_core_pkg::XLEN-1:0] pc_q;
    logic [rv_core_pkg::XLEN-1:0] addr_q;
    logic                         inflight_q;

    // Issue only while at least two more entries fit in the queue,
    // one for the word in flight and one for this request
    assign o_imem_req  = !i_rst && !i_almost_full;
    assign o_imem_addr = pc_q;

    // No branches, so the PC only moves forward
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc_q       <= '0;
            inflight_q <= 1'b0;
        end else begin
            inflight_q <= o_imem_req;
            if (o_imem_req) begin
                pc_q <= pc_q + rv_core_pkg::XLEN'(4);
            end
        end
    end

    // Address of the word now in flight
    always_ff @(posedge clk) begin
        if (o_imem_req) begin
            addr_q <= pc_q;
        end
    end

    // Memory answers one cycle after the strobe, push it straight through
    assign o_push = inflight_q;

    always_comb begin
        o_entry.pc   = addr_q;
        o_entry.inst = i_imem_rdata;
    end

endmodule

`default_nettype wire

// ==== logic/rv_inst_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_inst_queue (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic                      i_push,
    input  rv_core_pkg::fetch_entry_t i_entry,
    input  logic                      i_pop,
    output rv_core_pkg::fetch_entry_t o_head,
    output logic                      o_empty,
    output logic                      o_almost_full
);

    rv_core_pkg::fetch_entry_t mem [rv_core_pkg::QUEUE_DEPTH];

    logic [rv_core_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [rv_core_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [rv_core_pkg::QUEUE_PTR_W:0]   count_q;
    logic                                full;
    logic                                do_push;
    logic                                do_pop;

    // Occupancy levels
    assign full          = (count_q == (rv_core_pkg::QUEUE_PTR_W + 1)'(rv_core_pkg::QUEUE_DEPTH));
    assign o_empty       = (count_q == '0);
    assign o_almost_full =
        (count_q >= (rv_core_pkg::QUEUE_PTR_W + 1)'(rv_core_pkg::QUEUE_DEPTH - 1));

    // A push into a full queue still lands when the head leaves this cycle
    assign do_pop  = i_pop && !o_empty;
    assign do_push = i_push && (!full || do_pop);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= i_entry;
        end
    end

    // Head is visible in the same cycle it becomes valid
    assign o_head = mem[rd_ptr_q];

endmodule

`default_nettype wire

// ==== logic/rv_execute_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_execute_unit (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic                      i_hold,
    input  rv_core_pkg::fetch_entry_t i_head,
    input  logic                      i_empty,
    output logic                      o_pop,
    output rv_core_pkg::retire_t      o_retire
);

    logic [rv_core_pkg::XLEN-1:0] regs [rv_core_pkg::NUM_REGS];

    rv_core_pkg::rv_inst_u                inst;
    logic [6:0]                           opcode;
    logic [2:0]                           funct3;
    logic [rv_core_pkg::REG_ADDR_W-1:0]   rs1_idx;
    logic [rv_core_pkg::REG_ADDR_W-1:0]   rs2_idx;
    logic [rv_core_pkg::REG_ADDR_W-1:0]   rd_idx;
    logic [rv_core_pkg::XLEN-1:0]         rs1_val;
    logic [rv_core_pkg::XLEN-1:0]         rs2_val;
    logic [rv_core_pkg::XLEN-1:0]         op_b;
    logic [rv_core_pkg::XLEN-1:0]         alu_res;
    logic [rv_core_pkg::XLEN-1:0]         result;
    logic [4:0]                           shamt;
    logic                                 alt_op;
    logic                                 is_lui;
    logic                                 legal;
    logic                                 wr_en;

    // Consume one entry per cycle unless held
    assign o_pop = !i_empty && !i_hold;

    assign inst    = i_head.inst;
    assign opcode  = inst.r.opcode;
    assign funct3  = inst.r.funct3;
    assign rs1_idx = inst.r.rs1;
    assign rs2_idx = inst.r.rs2;
    assign rd_idx  = inst.r.rd;

    // x0 reads as zero
    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    // Decode through the format view
    always_comb begin
        op_b   = rs2_val;
        alt_op = 1'b0;
        is_lui = 1'b0;
        legal  = 1'b1;
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                // funct7 bit 5 picks SUB and SRA
                alt_op = inst.r.funct7[5];
            end
            rv_core_pkg::OPC_OP_IMM: begin
                op_b   = {{(rv_core_pkg::XLEN - 12){inst.i.imm12[11]}}, inst.i.imm12};
                // No SUBI, only SRAI uses the alternate bit
                alt_op = (funct3 == rv_core_pkg::F3_SRL_SRA) && inst.i.imm12[10];
            end
            rv_core_pkg::OPC_LUI: begin
                is_lui = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    assign shamt = op_b[4:0];

    // ALU
    always_comb begin
        case (funct3)
            rv_core_pkg::F3_ADD_SUB: alu_res = alt_op ? rs1_val - op_b : rs1_val + op_b;
            rv_core_pkg::F3_SLL:     alu_res = rs1_val << shamt;
            rv_core_pkg::F3_SLT: begin
                alu_res = {{(rv_core_pkg::XLEN - 1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            end
            rv_core_pkg::F3_SLTU: begin
                alu_res = {{(rv_core_pkg::XLEN - 1){1'b0}}, rs1_val < op_b};
            end
            rv_core_pkg::F3_XOR:     alu_res = rs1_val ^ op_b;
            rv_core_pkg::F3_SRL_SRA: begin
                if (alt_op) begin
                    alu_res = $signed(rs1_val) >>> shamt;
                end else begin
                    alu_res = rs1_val >> shamt;
                end
            end
            rv_core_pkg::F3_OR:      alu_res = rs1_val | op_b;
            default:                 alu_res = rs1_val & op_b;
        endcase
    end

    assign result = is_lui ? {inst.u.imm20, 12'b0} : alu_res;

    // Illegal words and x0 targets leave the register file alone
    assign wr_en = o_pop && legal && (rd_idx != '0);

    // Write-back lands at the popping edge, so the next entry sees it
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int k = 0; k < rv_core_pkg::NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en) begin
            regs[rd_idx] <= result;
        end
    end

    // Retire report
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_retire.valid <= 1'b0;
        end else begin
            o_retire.valid <= o_pop;
            if (o_pop) begin
                o_retire.pc      <= i_head.pc;
                o_retire.rd      <= legal ? rd_idx : '0;
                o_retire.wdata   <= (legal && rd_idx != '0) ? result : '0;
                o_retire.illegal <= !legal;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv_core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core_top (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic                         i_hold,
    input  logic [rv_core_pkg::XLEN-1:0] i_imem_rdata,
    output logic                         o_imem_req,
    output logic [rv_core_pkg::XLEN-1:0] o_imem_addr,
    output rv_core_pkg::retire_t         o_retire
);

    // Fetch to queue
    logic                      fetch_push;
    rv_core_pkg::fetch_entry_t fetch_entry;
    logic                      queue_almost_full;

    // Queue to execute
    rv_core_pkg::fetch_entry_t queue_head;
    logic                      queue_empty;
    logic                      exec_pop;

    rv_fetch_unit fetch0 (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_almost_full (queue_almost_full),
        .i_imem_rdata  (i_imem_rdata),
        .o_imem_req    (o_imem_req),
        .o_imem_addr   (o_imem_addr),
        .o_push        (fetch_push),
        .o_entry       (fetch_entry)
    );

    rv_inst_queue queue0 (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_push        (fetch_push),
        .i_entry       (fetch_entry),
        .i_pop         (exec_pop),
        .o_head        (queue_head),
        .o_empty       (queue_empty),
        .o_almost_full (queue_almost_full)
    );

    rv_execute_unit exec0 (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_hold   (i_hold),
        .i_head   (queue_head),
        .i_empty  (queue_empty),
        .o_pop    (exec_pop),
        .o_retire (o_retire)
    );

endmodule

`default_nettype wire

// ==== tests/rv_core_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core_sva (
    input logic                 clk,
    input logic                 i_rst,
    input logic                 i_hold,
    input logic                 o_imem_req,
    input rv_core_pkg::retire_t o_retire
);

    logic [rv_core_pkg::XLEN-1:0] last_pc;
    logic                         have_last;
    int                           fail_count = 0;

    // Most recent retire PC since reset
    always_ff @(posedge clk) begin
        if (i_rst) begin
            have_last <= 1'b0;
            last_pc   <= '0;
        end else if (o_retire.valid) begin
            have_last <= 1'b1;
            last_pc   <= o_retire.pc;
        end
    end

    // No fetch in reset and no retire just after a reset edge
    quiet_in_reset: assert property (
        @(posedge clk) i_rst |-> !o_imem_req ##1 !o_retire.valid)
        else begin
            $error("fetch request or retire report seen during reset");
            fail_count++;
        end

    // A held cycle pops nothing, so nothing retires after it
    no_retire_after_hold: assert property (
        @(posedge clk) disable iff (i_rst) i_hold |=> !o_retire.valid)
        else begin
            $error("retire reported right after a held cycle");
            fail_count++;
        end

    retire_pc_step: assert property (
        @(posedge clk) disable iff (i_rst)
        (o_retire.valid && have_last) |-> o_retire.pc == last_pc + rv_core_pkg::XLEN'(4))
        else begin
            $error("retire PC did not advance by 4");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;

    localparam int MEM_WORDS   = 64;
    localparam int HOLD_PCT    = 40;
    localparam int RESET_AFTER = 6;

    logic                         clk;
    logic                         i_rst;
    logic                         i_hold;
    logic [rv_core_pkg::XLEN-1:0] i_imem_rdata;
    logic                         o_imem_req;
    logic [rv_core_pkg::XLEN-1:0] o_imem_addr;
    rv_core_pkg::retire_t         o_retire;

    // Program image and expected retire list
    logic [31:0] prog_mem [MEM_WORDS];
    int          prog_words;
    int          exp_test [$];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_val [$];
    logic        exp_ill [$];

    // Memory model, one request in flight
    logic        pend_req;
    logic [31:0] pend_addr;

    rv_core_pkg::retire_t seen;
    bit hold_random;
    int cycle_count;
    int cycle_limit;
    int test_errs;
    int tests_passed;
    int tests_failed;
    int checks_passed;
    int checks_failed;

    rv_core_top dut0 (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_hold       (i_hold),
        .i_imem_rdata (i_imem_rdata),
        .o_imem_req   (o_imem_req),
        .o_imem_addr  (o_imem_addr),
        .o_retire     (o_retire)
    );

    bind rv_core_top rv_core_sva sva0 (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_hold     (i_hold),
        .o_imem_req (o_imem_req),
        .o_retire   (o_retire)
    );

    always #10 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d cycles before all retirements were seen",
                     cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // Memory takes the request at the edge, answers during the next cycle
    always @(posedge clk) begin
        pend_req  <= o_imem_req;
        pend_addr <= o_imem_addr;
    end

    task automatic load_vectors(output bit ok);
        int          fd;
        int          n;
        string       tag;
        string       rest;
        logic [31:0] addr;
        logic [31:0] word;
        int          test_id;
        int          rd;
        int          ill;
        fd = $fopen("tests/rv_core_vectors.txt", "r");
        ok = (fd != 0);
        prog_words = 0;
        if (ok) begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "P") begin
                    n = $fscanf(fd, "%h %h", addr, word);
                    ok = ok && (n == 2) && (addr[31:2] < MEM_WORDS);
                    prog_mem[addr[31:2]] = word;
                    if (int'(addr[31:2]) >= prog_words) begin
                        prog_words = int'(addr[31:2]) + 1;
                    end
                end else if (tag == "E") begin
                    n = $fscanf(fd, "%d %h %d %h %d", test_id, addr, rd, word, ill);
                    ok = ok && (n == 5);
                    exp_test.push_back(test_id);
                    exp_pc.push_back(addr);
                    exp_rd.push_back(rd[4:0]);
                    exp_val.push_back(word);
                    exp_ill.push_back(ill[0]);
                end else begin
                    // Comment, drop the rest of the line
                    n = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
        ok = ok && (exp_pc.size() > 0);
    endtask

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (addr[31:2] < prog_words) begin
            return prog_mem[addr[31:2]];
        end
        return rv_core_pkg::NOP_WORD;
    endfunction

    // Sample outputs first, then drive the inputs for the next half cycle
    task automatic next_cycle();
        @(negedge clk);
        seen = o_retire;
        i_imem_rdata = pend_req ? word_at(pend_addr) : rv_core_pkg::NOP_WORD;
        i_hold = hold_random && (($urandom % 100) < HOLD_PCT);
    endtask

    task automatic apply_reset();
        hold_random = 1'b0;
        i_rst = 1'b1;
        next_cycle();
        next_cycle();
        i_rst = 1'b0;
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) begin
            checks_passed++;
        end else begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            checks_failed++;
            test_errs++;
        end
    endtask

    task automatic check_retire(input int idx);
        compare_field("o_retire.pc", seen.pc, exp_pc[idx]);
        compare_field("o_retire.rd", 32'(seen.rd), 32'(exp_rd[idx]));
        compare_field("o_retire.wdata", seen.wdata, exp_val[idx]);
        compare_field("o_retire.illegal", 32'(seen.illegal), 32'(exp_ill[idx]));
    endtask

    task automatic finish_test(input int id);
        string name;
        case (id)
            1:       name = "register arithmetic and logic";
            2:       name = "immediates, shifts and upper immediate";
            3:       name = "program order and dependencies";
            4:       name = "x0 writes and illegal opcode";
            5:       name = "back-pressure under random hold";
            default: name = "restart after mid-run reset";
        endcase
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", id, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", id, name, test_errs);
        end
        test_errs = 0;
    endtask

    // report_id 0 reports by the file's test ids, below 0 reports nothing
    task automatic run_sequence(input bit with_hold, input int stop_after, input int report_id);
        int idx;
        idx = 0;
        hold_random = with_hold;
        while (idx < exp_pc.size() && idx < stop_after) begin
            next_cycle();
            if (seen.valid) begin
                check_retire(idx);
                idx++;
                if (report_id == 0 &&
                    (idx == exp_pc.size() || exp_test[idx] != exp_test[idx - 1])) begin
                    finish_test(exp_test[idx - 1]);
                end
            end
        end
        hold_random = 1'b0;
        if (report_id > 0) begin
            finish_test(report_id);
        end
    endtask

    initial begin
        bit ok;
        clk = 1'b0;
        i_rst = 1'b1;
        i_hold = 1'b0;
        i_imem_rdata = rv_core_pkg::NOP_WORD;
        hold_random = 1'b0;
        cycle_count = 0;
        cycle_limit = 100;
        test_errs = 0;
        tests_passed = 0;
        tests_failed = 0;
        checks_passed = 0;
        checks_failed = 0;
        void'($urandom(57994));
        load_vectors(ok);
        if (!ok) begin
            $display("Could not read a usable vector list from tests/rv_core_vectors.txt");
            $display("sim failed");
            $finish;
        end else begin
            cycle_limit = 4 * (3 * exp_pc.size() + RESET_AFTER) + 100;
            apply_reset();
            run_sequence(1'b0, exp_pc.size(), 0);
            apply_reset();
            run_sequence(1'b1, exp_pc.size(), 5);
            // Stop part way, reset, then the whole program again
            apply_reset();
            run_sequence(1'b0, RESET_AFTER, -1);
            apply_reset();
            run_sequence(1'b0, exp_pc.size(), 6);
            $display("tests passed %0d, tests failed %0d, checks passed %0d, checks failed %0d",
                     tests_passed, tests_failed, checks_passed, checks_failed);
            if (tests_failed == 0 && checks_failed == 0 && dut0.sva0.fail_count == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/rv_core_vectors.txt ====
# P lines hold a program word as address and instruction, both hex
# E lines hold test id, pc in hex, rd, value in hex and the illegal flag
# pc 0 reads x1 before the program writes it, so it only sees zero after a reset
P 00 00008ab3
P 04 06400093
P 08 ffb00113
P 0c 002081b3
P 10 40208233
P 14 0020f2b3
P 18 0020e333
P 1c 0020c3b3
P 20 00112433
P 24 001134b3
P 28 f3808513
P 2c fff0b593
P 30 fff0c613
P 34 01809693
P 38 80000737
P 3c 40475793
P 40 00475813
P 44 00100893
P 48 011888b3
P 4c 011888b3
P 50 00389913
P 54 00508013
P 58 001009b3
P 5c 00002083
P 60 00008a33
E 1 00 21 00000000 0
E 1 04 1 00000064 0
E 1 08 2 fffffffb 0
E 1 0c 3 0000005f 0
E 1 10 4 00000069 0
E 1 14 5 00000060 0
E 1 18 6 ffffffff 0
E 1 1c 7 ffffff9f 0
E 1 20 8 00000001 0
E 1 24 9 00000000 0
E 2 28 10 ffffff9c 0
E 2 2c 11 00000001 0
E 2 30 12 ffffff9b 0
E 2 34 13 64000000 0
E 2 38 14 80000000 0
E 2 3c 15 f8000000 0
E 2 40 16 08000000 0
E 3 44 17 00000001 0
E 3 48 17 00000002 0
E 3 4c 17 00000004 0
E 3 50 18 00000020 0
E 4 54 0 00000000 0
E 4 58 19 00000064 0
E 4 5c 0 00000000 1
E 4 60 20 00000064 0

// ==== src.f ====
logic/rv_core_pkg.sv
logic/rv_fetch_unit.sv
logic/rv_inst_queue.sv
logic/rv_execute_unit.sv
logic/rv_core_top.sv
tests/rv_core_sva.sv
tests/rv_core_tb.sv
